// File: logic/hins_defs.svh
`ifndef HINS_DEFS_SVH
`define HINS_DEFS_SVH

// ==============================
// bus widths
// ==============================
`define HINS_WORD_W 32              // one cpu register word
`define HINS_ADDR_W 4               // host address bits

// ==============================
// register map
// ==============================
`define HINS_A_SYNC_COUNT   4'd0    // sync period in cpu clocks
`define HINS_A_TIMER_RST    4'd1    // bit 0 holds the timer in clear
`define HINS_A_DAC_RST      4'd2    // bit 0 drives the dac reset pin
`define HINS_A_TIMER        4'd3    // live timer value, read only
`define HINS_A_SYNC_CNT_NOW 4'd4    // live sync counter, read only

// ==============================
// timer
// ==============================
// prescaler length in cpu clocks for one timer tick
`define HINS_TIMER_DIV 10000

`endif

// File: logic/hins_pkg.sv
`include "hins_defs.svh"

package hins_pkg;

    // ==============================
    // shared types
    // ==============================

    typedef logic [`HINS_WORD_W-1:0] hins_word_t;   // one register word
    typedef logic [`HINS_ADDR_W-1:0] hins_addr_t;   // host side address

    // ==============================
    // register addresses
    // ==============================

    // values come straight from the macro map
    typedef enum hins_addr_t {
        REG_SYNC_COUNT   = `HINS_A_SYNC_COUNT,      // rw sync period
        REG_TIMER_RST    = `HINS_A_TIMER_RST,       // rw timer clear
        REG_DAC_RST      = `HINS_A_DAC_RST,         // rw dac reset
        REG_TIMER        = `HINS_A_TIMER,           // ro timer value
        REG_SYNC_CNT_NOW = `HINS_A_SYNC_CNT_NOW     // ro sync counter
    } hins_reg_e;

endpackage

// File: logic/hins_varset.sv
`timescale 1ns/1ps

module hins_varset
    import hins_pkg::*;
(
    input  logic       pll_clk_cpu_int,
    input  logic       i_rst_n,
    // host port, four phase req/ack
    input  logic       i_host_req,
    input  logic       i_host_we,
    input  hins_addr_t i_host_addr,
    input  hins_word_t i_host_wdata,
    output logic       o_host_ack,
    output hins_word_t o_host_rdata,
    // live values from the timing units
    input  hins_word_t i_timer,
    input  hins_word_t i_sync_cnt,
    // register outputs
    output hins_word_t o_sync_count,
    output logic       o_timer_clr,
    output logic       o_dac_rst
);

    logic       req_meta;           // first sync stage
    logic       req_sync;           // req as seen by the bank
    logic       ack_q;              // handshake state
    logic       access;             // one cycle per transaction
    hins_reg_e  reg_sel;            // decoded address
    hins_word_t rd_data;            // read mux output
    hins_word_t rdata_q;            // read data held with ack

    hins_word_t sync_count_q;       // REG_SYNC_COUNT
    hins_word_t timer_rst_q;        // REG_TIMER_RST
    hins_word_t dac_rst_q;          // REG_DAC_RST

    // ==============================
    // host handshake
    // ==============================

    always_ff @(posedge pll_clk_cpu_int or negedge i_rst_n) begin
        if (!i_rst_n) begin
            req_meta <= 1'b0;
            req_sync <= 1'b0;
        end else begin
            req_meta <= i_host_req;         // two flop sync
            req_sync <= req_meta;
        end
    end

    // new access only once the previous ack has dropped
    assign access = req_sync && !ack_q;

    always_ff @(posedge pll_clk_cpu_int or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
        end else if (access) begin
            ack_q <= 1'b1;                  // phase 2
        end else if (!req_sync) begin
            ack_q <= 1'b0;                  // phase 4
        end
    end

    assign reg_sel = hins_reg_e'(i_host_addr);  // unmapped codes fall to default

    // ==============================
    // writable registers
    // ==============================

    always_ff @(posedge pll_clk_cpu_int or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync_count_q <= '0;
            timer_rst_q  <= '0;
            dac_rst_q    <= '0;
        end else if (access && i_host_we) begin    // lands with ack rise
            case (reg_sel)
                REG_SYNC_COUNT:   sync_count_q <= i_host_wdata;
                REG_TIMER_RST:    timer_rst_q  <= i_host_wdata;
                REG_DAC_RST:      dac_rst_q    <= i_host_wdata;
                REG_TIMER:        ;                 // read only
                REG_SYNC_CNT_NOW: ;                 // read only
                default:          ;                 // unmapped, dropped
            endcase
        end
    end

    // ==============================
    // read back
    // ==============================

    always_comb begin
        case (reg_sel)
            REG_SYNC_COUNT:   rd_data = sync_count_q;
            REG_TIMER_RST:    rd_data = timer_rst_q;
            REG_DAC_RST:      rd_data = dac_rst_q;
            REG_TIMER:        rd_data = i_timer;        // live value
            REG_SYNC_CNT_NOW: rd_data = i_sync_cnt;     // live value
            default:          rd_data = '0;             // unmapped reads zero
        endcase
    end

    // sampled once per read, stable while ack is high
    always_ff @(posedge pll_clk_cpu_int) begin
        if (access && !i_host_we) begin
            rdata_q <= rd_data;
        end
    end

    assign o_host_ack   = ack_q;
    assign o_host_rdata = rdata_q;

    assign o_sync_count = sync_count_q;     // full word to sync gen
    assign o_timer_clr  = timer_rst_q[0];   // only bit 0 clears
    assign o_dac_rst    = dac_rst_q[0];     // pin follows bit 0

endmodule

// File: logic/hins_sync_gen.sv
`timescale 1ns/1ps

module hins_sync_gen
    import hins_pkg::*;
(
    input  logic       pll_clk_cpu_int,
    input  logic       i_rst_n,
    input  hins_word_t i_sync_count,    // period in cpu clocks
    output logic       o_sync_out,      // one cycle pulse
    output hins_word_t o_sync_cnt       // running count for read back
);

    hins_word_t cnt_q;                  // period counter
    logic       park;                   // count of 0 stops the generator
    logic       wrap;                   // last cycle of the period

    // ==============================
    // wrap detect
    // ==============================

    assign park = (i_sync_count == '0);

    // >= so a lowered period still wraps at once
    assign wrap = !park && (cnt_q >= (i_sync_count - 1'b1));

    // ==============================
    // period counter
    // ==============================

    always_ff @(posedge pll_clk_cpu_int or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q <= '0;
        end else if (park || wrap) begin
            cnt_q <= '0;                // restart the period
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // pulse marks the final count of each period
    assign o_sync_out = wrap;
    assign o_sync_cnt = cnt_q;

endmodule

// File: logic/hins_timer.sv
`timescale 1ns/1ps
`include "hins_defs.svh"

module hins_timer
    import hins_pkg::*;
#(
    parameter int unsigned COUNTER_NUM = `HINS_TIMER_DIV   // clocks per tick
)(
    input  logic       pll_clk_cpu_int,
    input  logic       i_rst_n,
    input  logic       i_clr,           // holds everything at zero
    output hins_word_t o_timer          // tick count
);

    // at least one bit even for a divide by one
    localparam int unsigned       PRE_W    = (COUNTER_NUM > 1) ? $clog2(COUNTER_NUM) : 1;
    localparam logic [PRE_W-1:0]  PRE_LAST = PRE_W'(COUNTER_NUM - 1);

    logic [PRE_W-1:0] pre_q;            // prescaler
    logic             tick;             // prescaler wrap
    hins_word_t       timer_q;          // free running value

    assign tick = (pre_q == PRE_LAST);

    // ==============================
    // prescaler
    // ==============================

    always_ff @(posedge pll_clk_cpu_int or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pre_q <= '0;
        end else if (i_clr || tick) begin
            pre_q <= '0;                // clear or end of division
        end else begin
            pre_q <= pre_q + 1'b1;
        end
    end

    // ==============================
    // tick counter
    // ==============================

    always_ff @(posedge pll_clk_cpu_int or negedge i_rst_n) begin
        if (!i_rst_n) begin
            timer_q <= '0;
        end else if (i_clr) begin
            timer_q <= '0;
        end else if (tick) begin
            timer_q <= timer_q + 1'b1;  // wraps at 2^32
        end
    end

    assign o_timer = timer_q;

endmodule

// File: logic/hins_top.sv
`timescale 1ns/1ps
`include "hins_defs.svh"

module hins_top
    import hins_pkg::*;
#(
    parameter int unsigned TIMER_DIV = `HINS_TIMER_DIV     // timer prescale
)(
    input  logic       pll_clk_cpu_int,
    input  logic       RST_EXT_N,       // board reset
    input  logic       i_pll_locked,    // lock flag of the pll
    // host port
    input  logic       i_host_req,
    input  logic       i_host_we,
    input  hins_addr_t i_host_addr,
    input  hins_word_t i_host_wdata,
    output logic       o_host_ack,
    output hins_word_t o_host_rdata,
    // board pins
    output logic       o_sync_out,
    output logic       o_dac_rst
);

    logic       r_locked_sync1;     // lock sync stage 1
    logic       r_locked_sync2;     // lock sync stage 2
    logic       rst_sync_n;         // internal reset
    hins_word_t var_sync_count;     // period to sync gen
    hins_word_t var_sync_cnt_now;   // sync counter back to bank
    hins_word_t var_timer;          // timer value back to bank
    logic       var_timer_clr;      // timer clear from bank

    // ==============================
    // reset synchronizer
    // ==============================

    // released after lock is seen on two edges
    always_ff @(posedge pll_clk_cpu_int or negedge RST_EXT_N) begin
        if (!RST_EXT_N) begin
            r_locked_sync1 <= 1'b0;
            r_locked_sync2 <= 1'b0;
        end else begin
            r_locked_sync1 <= i_pll_locked;
            r_locked_sync2 <= r_locked_sync1;
        end
    end

    assign rst_sync_n = r_locked_sync2;   // lock loss re-asserts after two edges

    // ==============================
    // register bank
    // ==============================

    hins_varset u_varset (
        .pll_clk_cpu_int (pll_clk_cpu_int),
        .i_rst_n         (rst_sync_n),
        .i_host_req      (i_host_req),
        .i_host_we       (i_host_we),
        .i_host_addr     (i_host_addr),
        .i_host_wdata    (i_host_wdata),
        .o_host_ack      (o_host_ack),
        .o_host_rdata    (o_host_rdata),
        .i_timer         (var_timer),
        .i_sync_cnt      (var_sync_cnt_now),
        .o_sync_count    (var_sync_count),
        .o_timer_clr     (var_timer_clr),
        .o_dac_rst       (o_dac_rst)            // straight to the pin
    );

    // ==============================
    // timing units
    // ==============================

    hins_sync_gen u_sync_gen (
        .pll_clk_cpu_int (pll_clk_cpu_int),
        .i_rst_n         (rst_sync_n),
        .i_sync_count    (var_sync_count),
        .o_sync_out      (o_sync_out),
        .o_sync_cnt      (var_sync_cnt_now)
    );

    hins_timer #(
        .COUNTER_NUM     (TIMER_DIV)
    ) u_timer (
        .pll_clk_cpu_int (pll_clk_cpu_int),
        .i_rst_n         (rst_sync_n),
        .i_clr           (var_timer_clr),
        .o_timer         (var_timer)
    );

endmodule

// File: tb/hins_top_props.sv
`timescale 1ns/1ps

module hins_top_props (
    input logic pll_clk_cpu_int,
    input logic i_rst_n,            // bank reset
    input logic i_host_req,         // raw host request
    input logic i_host_ack          // bank acknowledge
);

    int unsigned fail_cnt = 0;      // polled by the testbench

    // ==============================
    // four phase host handshake
    // ==============================

    // bank answers only a pending request
    ack_needs_req: assert property (
        @(posedge pll_clk_cpu_int) disable iff (!i_rst_n)
        $rose(i_host_ack) |-> $past(i_host_req)
    ) else begin
        fail_cnt++;
        $error("ack rose while no request was pending");
    end

    // ack is held until the host lets go of req
    ack_holds: assert property (
        @(posedge pll_clk_cpu_int) disable iff (!i_rst_n)
        (i_host_ack && i_host_req) |=> i_host_ack
    ) else begin
        fail_cnt++;
        $error("ack dropped while req was still high");
    end

    // ==============================
    // reset
    // ==============================

    ack_low_in_reset: assert property (
        @(posedge pll_clk_cpu_int) !i_rst_n |-> !i_host_ack
    ) else begin
        fail_cnt++;
        $error("ack high while the bank is in reset");
    end

endmodule

// File: tb/tb_hins_top.sv
`timescale 1ns/1ps

module tb_hins_top
    import hins_pkg::*;
();

    localparam int unsigned TIMER_DIV = 8;      // short prescale for sim
    localparam int N_TRAFFIC    = 200;          // random host accesses
    localparam int N_XACT       = N_TRAFFIC + 60;   // plus directed accesses
    localparam int ACK_LIMIT    = 10;           // cycles per handshake phase
    localparam int SYNC_WAIT    = 5 * 20 + 50;  // longest periods, quiet window
    localparam int TIMER_WAIT   = 20 * TIMER_DIV;
    localparam int WATCHDOG_CYC = N_XACT * 10 + SYNC_WAIT + TIMER_WAIT + 400;

    logic       pll_clk_cpu_int;
    logic       RST_EXT_N;
    logic       i_pll_locked;
    logic       i_host_req;
    logic       i_host_we;
    hins_addr_t i_host_addr;
    hins_word_t i_host_wdata;
    logic       o_host_ack;
    hins_word_t o_host_rdata;
    logic       o_sync_out;
    logic       o_dac_rst;

    hins_word_t  model [16];                // expected register contents
    logic [31:0] lcg_state = 32'd40;        // fixed seed

    hins_top #(
        .TIMER_DIV       (TIMER_DIV)
    ) DUT (
        .pll_clk_cpu_int (pll_clk_cpu_int),
        .RST_EXT_N       (RST_EXT_N),
        .i_pll_locked    (i_pll_locked),
        .i_host_req      (i_host_req),
        .i_host_we       (i_host_we),
        .i_host_addr     (i_host_addr),
        .i_host_wdata    (i_host_wdata),
        .o_host_ack      (o_host_ack),
        .o_host_rdata    (o_host_rdata),
        .o_sync_out      (o_sync_out),
        .o_dac_rst       (o_dac_rst)
    );

    bind hins_varset hins_top_props u_props (
        .pll_clk_cpu_int (pll_clk_cpu_int),
        .i_rst_n         (i_rst_n),
        .i_host_req      (i_host_req),
        .i_host_ack      (o_host_ack)
    );

    initial begin
        pll_clk_cpu_int = 1'b0;
        forever #10 pll_clk_cpu_int = ~pll_clk_cpu_int;    // 20 ns period
    end

    // ==============================
    // helpers
    // ==============================

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input hins_word_t got,
                               input hins_word_t exp);
        if (got != exp) begin
            stop_run($sformatf("FAILED at %0t: %s got 0x%08h expected 0x%08h",
                               $time, name, got, exp));
        end
    endtask

    // every step lands 2 ns after the rising edge
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge pll_clk_cpu_int);
            #2;
        end
    endtask

    task automatic host_access(input logic we, input hins_addr_t addr,
                               input hins_word_t wdata, input int hold,
                               output hins_word_t rdata);
        int waited;
        waited       = 0;
        i_host_req   = 1'b1;            // phase 1
        i_host_we    = we;
        i_host_addr  = addr;
        i_host_wdata = wdata;
        while (o_host_ack != 1'b1) begin
            wait_cycles(1);
            waited++;
            if (waited > ACK_LIMIT) begin
                stop_run("host handshake timed out, ack never rose");
            end
        end
        rdata      = o_host_rdata;      // valid while ack is high
        wait_cycles(hold);              // back pressure, req held with ack
        i_host_req = 1'b0;              // phase 3
        waited     = 0;
        while (o_host_ack != 1'b0) begin
            wait_cycles(1);
            waited++;
            if (waited > ACK_LIMIT) begin
                stop_run("host handshake timed out, ack never fell");
            end
        end
    endtask

    task automatic host_write(input hins_addr_t addr, input hins_word_t data);
        hins_word_t unused;
        host_access(1'b1, addr, data, 0, unused);
    endtask

    task automatic host_read(input hins_addr_t addr, output hins_word_t data);
        host_access(1'b0, addr, '0, 0, data);
    endtask

    // read value implied by the register map
    function automatic hins_word_t expect_read(input hins_addr_t a);
        case (a)
            REG_SYNC_COUNT, REG_TIMER_RST, REG_DAC_RST: return model[a];
            default: return '0;         // timer held clear, unmapped zero
        endcase
    endfunction

    // ==============================
    // test steps
    // ==============================

    task automatic check_reset_state(input string when);
        hins_word_t rd;
        for (int a = 0; a < 16; a++) begin
            if (hins_addr_t'(a) != REG_TIMER) begin    // timer free runs
                host_read(hins_addr_t'(a), rd);
                check_value($sformatf("o_host_rdata %s addr 0x%0h", when, a), rd, '0);
            end
        end
        check_value("o_sync_out", 32'(o_sync_out), '0);
        check_value("o_dac_rst", 32'(o_dac_rst), '0);
    endtask

    task automatic run_traffic();
        logic [31:0] r;
        hins_addr_t  addr;
        hins_word_t  data;
        hins_word_t  rd;
        logic        we;
        int          hold;
        for (int i = 0; i < N_TRAFFIC; i++) begin
            r    = lcg_next();
            we   = r[20];
            addr = r[31:28];            // unmapped codes too
            hold = int'(r[9:8]);        // 0 to 3 cycles of held req
            data = lcg_next();
            if (we) begin
                if (addr == REG_TIMER_RST) begin
                    data[0] = 1'b1;     // timer stays in clear
                end
                host_access(1'b1, addr, data, hold, rd);
                if (addr == REG_SYNC_COUNT || addr == REG_TIMER_RST ||
                    addr == REG_DAC_RST) begin
                    model[addr] = data;
                end
                if (addr == REG_DAC_RST) begin
                    check_value("o_dac_rst", 32'(o_dac_rst), 32'(data[0]));
                end
            end else begin
                host_access(1'b0, addr, '0, hold, rd);
                // live sync counter is known only while parked
                if (addr != REG_SYNC_CNT_NOW || model[REG_SYNC_COUNT] == '0) begin
                    check_value("o_host_rdata", rd, expect_read(addr));
                end
            end
        end
    endtask

    // cycles until the next sampled pulse
    task automatic wait_pulse(input int n, output int gap);
        gap = 0;
        do begin
            wait_cycles(1);
            gap++;
            if (gap > 2 * n + 8) begin
                stop_run("no sync pulse appeared within two periods");
            end
        end while (o_sync_out != 1'b1);
    endtask

    task automatic check_sync_period();
        int         n;
        int         gap;
        hins_word_t rd;
        n = 2 + int'((lcg_next() >> 16) % 19);     // 2 to 20
        host_write(REG_SYNC_COUNT, hins_word_t'(n));
        model[REG_SYNC_COUNT] = hins_word_t'(n);
        wait_pulse(n, gap);                         // align to a pulse
        for (int p = 0; p < 3; p++) begin
            wait_pulse(n, gap);
            check_value("o_sync_out spacing", hins_word_t'(gap), hins_word_t'(n));
        end
        host_write(REG_SYNC_COUNT, '0);
        model[REG_SYNC_COUNT] = '0;
        for (int c = 0; c < 50; c++) begin
            wait_cycles(1);
            check_value("o_sync_out parked", 32'(o_sync_out), '0);
        end
        host_read(REG_SYNC_CNT_NOW, rd);
        check_value("o_host_rdata sync counter parked", rd, '0);
    endtask

    task automatic check_timer();
        int         k;
        hins_word_t rd;
        hins_word_t lo;
        hins_word_t hi;
        host_read(REG_TIMER, rd);
        check_value("o_host_rdata timer held", rd, '0);
        k  = 5 + int'((lcg_next() >> 16) % 16);
        lo = hins_word_t'(k);
        hi = hins_word_t'(k + 3);                   // handshake slack
        host_write(REG_TIMER_RST, '0);
        model[REG_TIMER_RST] = '0;
        wait_cycles(k * TIMER_DIV);
        host_read(REG_TIMER, rd);
        check_value($sformatf("o_host_rdata timer 0x%0h in %0d..%0d", rd, k, k + 3),
                    32'(rd >= lo && rd <= hi), 32'd1);
        host_write(REG_TIMER_RST, 32'd1);
        model[REG_TIMER_RST] = 32'd1;
    endtask

    task automatic check_lock_loss();
        host_write(REG_DAC_RST, 32'd1);
        host_write(REG_SYNC_COUNT, 32'd7);
        check_value("o_dac_rst", 32'(o_dac_rst), 32'd1);
        i_pll_locked = 1'b0;
        wait_cycles(5);
        check_value("o_dac_rst in lock loss", 32'(o_dac_rst), '0);
        i_pll_locked = 1'b1;
        wait_cycles(4);                 // two edges to release, then slack
        for (int a = 0; a < 16; a++) begin
            model[a] = '0;
        end
        check_reset_state("after lock loss");
    endtask

    // ==============================
    // main sequence
    // ==============================

    initial begin
        RST_EXT_N    = 1'b0;
        i_pll_locked = 1'b0;
        i_host_req   = 1'b0;
        i_host_we    = 1'b0;
        i_host_addr  = '0;
        i_host_wdata = '0;
        for (int a = 0; a < 16; a++) begin
            model[a] = '0;
        end
        repeat (16) @(posedge pll_clk_cpu_int);
        #2;
        RST_EXT_N = 1'b1;
        wait_cycles(1);
        i_pll_locked = 1'b1;            // lock after board reset
        wait_cycles(4);

        check_reset_state("after reset");
        host_write(REG_TIMER_RST, 32'd1);
        model[REG_TIMER_RST] = 32'd1;
        run_traffic();
        check_sync_period();
        check_timer();
        check_lock_loss();

        if (DUT.u_varset.u_props.fail_cnt == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            stop_run("a bound assertion on the host port or reset failed");
        end
    end

    // stops at the first assertion failure
    initial begin
        forever begin
            @(posedge pll_clk_cpu_int);
            #1;
            if (DUT.u_varset.u_props.fail_cnt != 0) begin
                stop_run("a bound assertion on the host port or reset failed");
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge pll_clk_cpu_int);
        stop_run("watchdog expired before the test sequence finished");
    end

endmodule

// File: compile.f
+incdir+logic
logic/hins_pkg.sv
logic/hins_varset.sv
logic/hins_sync_gen.sv
logic/hins_timer.sv
logic/hins_top.sv
tb/hins_top_props.sv
tb/tb_hins_top.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_hins_top
FILELIST := compile.f
OBJ_DIR  := obj_dir
RUN_ARGS := +verilator+error+limit+100

.PHONY: simulate clean

# build the testbench, then run it; a $fatal in the run gives a failing status
simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)
